// File: bench/mul_vectors.txt
// Columns: operand A, operand B, expected signed 64-bit product A*B
// All values in two's-complement hex
00000000 00000000 0000000000000000
00000001 00000001 0000000000000001
FFFFFFFF 00000001 FFFFFFFFFFFFFFFF
FFFFFFFF FFFFFFFF 0000000000000001
80000000 FFFFFFFF 0000000080000000
80000000 80000000 4000000000000000
7FFFFFFF 7FFFFFFF 3FFFFFFF00000001
80000000 7FFFFFFF C000000080000000
00001000 FFFFF000 FFFFFFFFFF000000
00000002 FFFFFFFD FFFFFFFFFFFFFFFA
FFFFFFF9 00000005 FFFFFFFFFFFFFFDD
FFFFFFF9 FFFFFFFB 0000000000000023
00010000 00010000 0000000100000000
0000FFFF 0000FFFF 00000000FFFE0001
7FFFFFFF FFFFFFFF FFFFFFFF80000001
00000064 FFFFFF9C FFFFFFFFFFFFD8F0
00000003 80000000 FFFFFFFE80000000

// File: bench/tb_mul_periph.sv
`timescale 1ns/1ns
`default_nettype none

`include "mul_consts.svh"

module tb_mul_periph import mul_pkg::*; ();

    localparam int NUM_VEC         = 17;
    localparam int NUM_RAND        = 64;
    localparam int RESET_CYCLES    = 16;
    localparam int HS_LIMIT        = 50;
    localparam int POLL_LIMIT      = 40;
    // Vector and random products plus the directed ones
    localparam int NUM_OPS         = NUM_VEC + NUM_RAND + 8;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 200 + RESET_CYCLES;

    logic        clk;
    logic        rst;
    addr_t       awaddr;
    logic        awvalid;
    logic        awready;
    word_t       wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    addr_t       araddr;
    logic        arvalid;
    logic        arready;
    word_t       rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    // Three words per vector: A, B, product
    logic [63:0] vec_mem [0:3*NUM_VEC-1];
    int          seed;
    int          err_count;
    int          test_count;
    int          failed_tests;

    mul_periph_top i_mul_periph_top (
        .clk_i     (clk),
        .rst_i     (rst),
        .awaddr_i  (awaddr),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .wdata_i   (wdata),
        .wstrb_i   (wstrb),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .bresp_o   (bresp),
        .bvalid_o  (bvalid),
        .bready_i  (bready),
        .araddr_i  (araddr),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .rdata_o   (rdata),
        .rresp_o   (rresp),
        .rvalid_o  (rvalid),
        .rready_i  (rready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // *************************************************************************
    // Reporting and reference model
    // *************************************************************************
    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("MISMATCH at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
        err_count++;
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        err_count++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("test %s: passed", name);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    function automatic prod_t signed_product(input word_t a, input word_t b);
        logic signed [63:0] wide_a;
        logic signed [63:0] wide_b;
        wide_a = {{32{a[31]}}, a};
        wide_b = {{32{b[31]}}, b};
        return wide_a * wide_b;
    endfunction

    // *************************************************************************
    // AXI4-Lite host, outputs sampled on the rising edge
    // *************************************************************************
    task automatic axi_write(input addr_t addr, input word_t data, input int hold);
        int waited;
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= 4'hF;
        wvalid  <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!(awready && wready) && waited < HS_LIMIT);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        if (!(awready && wready)) begin
            report_failure("write address and data were never accepted");
            return;
        end
        bready <= (hold == 0);
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!bvalid && waited < HS_LIMIT);
        if (!bvalid) begin
            report_failure("write response never arrived");
            bready <= 1'b0;
            return;
        end
        if (hold > 0) begin
            for (int i = 0; i < hold; i++) begin
                @(posedge clk);
                if (bvalid !== 1'b1) report_mismatch("bvalid", 64'd1, 64'(bvalid));
            end
            bready <= 1'b1;
            @(posedge clk);
            if (bvalid !== 1'b1) report_mismatch("bvalid", 64'd1, 64'(bvalid));
        end
        if (bresp !== 2'b00) report_mismatch("bresp", 64'd0, 64'(bresp));
        bready <= 1'b0;
    endtask

    task automatic axi_read(input addr_t addr, input int hold, output word_t data);
        int    waited;
        word_t first;
        data = 'x;
        araddr  <= addr;
        arvalid <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!arready && waited < HS_LIMIT);
        arvalid <= 1'b0;
        if (!arready) begin
            report_failure("read address was never accepted");
            return;
        end
        rready <= (hold == 0);
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!rvalid && waited < HS_LIMIT);
        if (!rvalid) begin
            report_failure("read data never arrived");
            rready <= 1'b0;
            return;
        end
        first = rdata;
        data  = first;
        if (hold > 0) begin
            for (int i = 0; i < hold; i++) begin
                @(posedge clk);
                if (rvalid !== 1'b1) report_mismatch("rvalid", 64'd1, 64'(rvalid));
                if (rdata !== first) report_mismatch("rdata", 64'(first), 64'(rdata));
            end
            rready <= 1'b1;
            @(posedge clk);
            if (rvalid !== 1'b1) report_mismatch("rvalid", 64'd1, 64'(rvalid));
            data = rdata;
        end
        if (rresp !== 2'b00) report_mismatch("rresp", 64'd0, 64'(rresp));
        rready <= 1'b0;
    endtask

    task automatic wait_done();
        word_t status;
        int    polls;
        polls  = 0;
        status = '0;
        while (!status[1] && polls < POLL_LIMIT) begin
            axi_read(`MUL_REG_STATUS, 0, status);
            polls++;
        end
        if (status[1] !== 1'b1) report_failure("STATUS never showed done after a start");
    endtask

    task automatic read_result(output prod_t result);
        word_t lo;
        word_t hi;
        axi_read(`MUL_REG_RES_LO, 0, lo);
        axi_read(`MUL_REG_RES_HI, 0, hi);
        result = {hi, lo};
    endtask

    task automatic run_product(input word_t a, input word_t b, output prod_t result);
        axi_write(`MUL_REG_OPA, a, 0);
        axi_write(`MUL_REG_OPB, b, 0);
        axi_write(`MUL_REG_CTRL, 32'h1, 0);
        wait_done();
        read_result(result);
    endtask

    // *************************************************************************
    // Tests
    // *************************************************************************
    task automatic test_vectors();
        int    errs_before;
        prod_t result;
        errs_before = err_count;
        for (int i = 0; i < NUM_VEC; i++) begin
            run_product(vec_mem[3*i][31:0], vec_mem[3*i+1][31:0], result);
            if (result !== vec_mem[3*i+2]) begin
                report_mismatch($sformatf("product[%0d]", i), vec_mem[3*i+2], result);
            end
        end
        finish_test("vectors", errs_before);
    endtask

    task automatic test_random();
        int    errs_before;
        word_t a;
        word_t b;
        prod_t result;
        errs_before = err_count;
        for (int i = 0; i < NUM_RAND; i++) begin
            a = $random(seed);
            b = $random(seed);
            run_product(a, b, result);
            if (result !== signed_product(a, b)) begin
                report_mismatch($sformatf("random product %h*%h", a, b),
                                signed_product(a, b), result);
            end
        end
        finish_test("random", errs_before);
    endtask

    task automatic test_status();
        int    errs_before;
        word_t status;
        prod_t result;
        errs_before = err_count;
        run_product(32'd3, 32'd5, result);
        if (result !== 64'd15) report_mismatch("product", 64'd15, result);
        axi_read(`MUL_REG_STATUS, 0, status);
        if (status !== 32'h2) report_mismatch("status after done", 64'h2, 64'(status));
        // A new start clears done and sets busy
        axi_write(`MUL_REG_CTRL, 32'h1, 0);
        axi_read(`MUL_REG_STATUS, 0, status);
        if (status !== 32'h1) report_mismatch("status after start", 64'h1, 64'(status));
        wait_done();
        axi_read(`MUL_REG_STATUS, 0, status);
        if (status !== 32'h2) report_mismatch("status after done", 64'h2, 64'(status));
        finish_test("status", errs_before);
    endtask

    task automatic test_readback();
        int    errs_before;
        word_t data;
        errs_before = err_count;
        axi_write(`MUL_REG_OPA, 32'hA5A5_0F0F, 0);
        axi_write(`MUL_REG_OPB, 32'h1234_5678, 0);
        axi_read(`MUL_REG_OPA, 0, data);
        if (data !== 32'hA5A5_0F0F) report_mismatch("opa", 64'hA5A5_0F0F, 64'(data));
        axi_read(`MUL_REG_OPB, 0, data);
        if (data !== 32'h1234_5678) report_mismatch("opb", 64'h1234_5678, 64'(data));
        axi_read(5'h18, 0, data);
        if (data !== 32'h0) report_mismatch("unmapped 0x18", 64'h0, 64'(data));
        axi_read(5'h1C, 0, data);
        if (data !== 32'h0) report_mismatch("unmapped 0x1C", 64'h0, 64'(data));
        finish_test("readback", errs_before);
    endtask

    task automatic test_start_busy();
        int    errs_before;
        word_t status;
        prod_t result;
        errs_before = err_count;
        axi_write(`MUL_REG_OPA, 32'h0000_1234, 0);
        axi_write(`MUL_REG_OPB, 32'hFFFF_FF00, 0);
        axi_write(`MUL_REG_CTRL, 32'h1, 0);
        // Lands while the first operation is in flight
        axi_write(`MUL_REG_CTRL, 32'h1, 0);
        axi_write(`MUL_REG_OPA, 32'h7654_3210, 0);
        axi_write(`MUL_REG_OPB, 32'h0000_0003, 0);
        wait_done();
        read_result(result);
        if (result !== signed_product(32'h0000_1234, 32'hFFFF_FF00)) begin
            report_mismatch("first product", signed_product(32'h0000_1234, 32'hFFFF_FF00),
                            result);
        end
        axi_read(`MUL_REG_STATUS, 0, status);
        if (status !== 32'h2) report_mismatch("status after done", 64'h2, 64'(status));
        axi_write(`MUL_REG_CTRL, 32'h1, 0);
        wait_done();
        read_result(result);
        if (result !== signed_product(32'h7654_3210, 32'h0000_0003)) begin
            report_mismatch("second product", signed_product(32'h7654_3210, 32'h0000_0003),
                            result);
        end
        finish_test("start_busy", errs_before);
    endtask

    task automatic test_backpressure();
        int    errs_before;
        word_t data;
        errs_before = err_count;
        axi_write(`MUL_REG_OPA, 32'hC0FF_EE11, 6);
        axi_read(`MUL_REG_OPA, 6, data);
        if (data !== 32'hC0FF_EE11) report_mismatch("opa", 64'hC0FF_EE11, 64'(data));
        axi_write(`MUL_REG_OPB, 32'h0BAD_F00D, 0);
        axi_read(`MUL_REG_OPB, 0, data);
        if (data !== 32'h0BAD_F00D) report_mismatch("opb", 64'h0BAD_F00D, 64'(data));
        finish_test("backpressure", errs_before);
    endtask

    initial begin
        rst          = 1'b1;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = 4'h0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        seed         = 32'h871d7a97;
        err_count    = 0;
        test_count   = 0;
        failed_tests = 0;
        $readmemh("bench/mul_vectors.txt", vec_mem);
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_readback();
        test_vectors();
        test_random();
        test_status();
        test_start_busy();
        test_backpressure();
        $display("summary: %0d tests, %0d failed, %0d errors", test_count, failed_tests,
                 err_count);
        if (err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
rtl/mul_pkg.sv
rtl/bk_adder32.sv
rtl/wallace_mul32.sv
rtl/mul_ctrl.sv
rtl/axil_mul_regs.sv
rtl/mul_periph_top.sv
bench/tb_mul_periph.sv

// File: include/mul_consts.svh
`ifndef MUL_CONSTS_SVH
`define MUL_CONSTS_SVH

// Register map of the AXI4-Lite slave
`define MUL_ADDR_W      5

`define MUL_REG_OPA     5'h00
`define MUL_REG_OPB     5'h04
`define MUL_REG_CTRL    5'h08
`define MUL_REG_STATUS  5'h0C
`define MUL_REG_RES_LO  5'h10
`define MUL_REG_RES_HI  5'h14

// Cycles from valid in to valid out of the multiplier
`define MUL_LATENCY     3

`endif

// File: rtl/axil_mul_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "mul_consts.svh"

module axil_mul_regs import mul_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  addr_t       awaddr_i,
    input  logic        awvalid_i,
    output logic        awready_o,
    input  word_t       wdata_i,
    input  logic [3:0]  wstrb_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    output logic [1:0]  bresp_o,
    output logic        bvalid_o,
    input  logic        bready_i,
    input  addr_t       araddr_i,
    input  logic        arvalid_i,
    output logic        arready_o,
    output word_t       rdata_o,
    output logic [1:0]  rresp_o,
    output logic        rvalid_o,
    input  logic        rready_i,
    output word_t       opa_o,
    output word_t       opb_o,
    output logic        start_o,
    input  logic        busy_i,
    input  logic        done_i,
    input  logic        prod_valid_i,
    input  prod_t       prod_i
);

    logic  wr_ready_q;
    logic  bvalid_q;
    logic  rd_ready_q;
    logic  rvalid_q;
    logic  wr_hs;
    logic  rd_hs;
    logic  start_q;
    word_t opa_q;
    word_t opb_q;
    word_t res_lo_q;
    word_t res_hi_q;
    word_t rd_word;
    word_t rdata_q;

    assign wr_hs = wr_ready_q & awvalid_i & wvalid_i;
    assign rd_hs = rd_ready_q & arvalid_i;

    // *************************************************************************
    // Handshakes
    // *************************************************************************
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ready_q <= 1'b0;
            bvalid_q   <= 1'b0;
            rd_ready_q <= 1'b0;
            rvalid_q   <= 1'b0;
        end else begin
            wr_ready_q <= !wr_ready_q && awvalid_i && wvalid_i && !bvalid_q;
            if (wr_hs) begin
                bvalid_q <= 1'b1;
            end else if (bready_i) begin
                bvalid_q <= 1'b0;
            end
            rd_ready_q <= !rd_ready_q && arvalid_i && !rvalid_q;
            if (rd_hs) begin
                rvalid_q <= 1'b1;
            end else if (rready_i) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // Register writes and product capture
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            opa_q    <= '0;
            opb_q    <= '0;
            res_lo_q <= '0;
            res_hi_q <= '0;
            start_q  <= 1'b0;
        end else begin
            start_q <= wr_hs && (awaddr_i == `MUL_REG_CTRL) && wdata_i[0];
            if (wr_hs && awaddr_i == `MUL_REG_OPA) begin
                opa_q <= wdata_i;
            end
            if (wr_hs && awaddr_i == `MUL_REG_OPB) begin
                opb_q <= wdata_i;
            end
            if (prod_valid_i) begin
                res_lo_q <= prod_i[31:0];
                res_hi_q <= prod_i[63:32];
            end
        end
    end

    // *************************************************************************
    // Read path
    // *************************************************************************
    always_comb begin
        case (araddr_i)
            `MUL_REG_OPA:    rd_word = opa_q;
            `MUL_REG_OPB:    rd_word = opb_q;
            `MUL_REG_STATUS: rd_word = {30'd0, done_i, busy_i};
            `MUL_REG_RES_LO: rd_word = res_lo_q;
            `MUL_REG_RES_HI: rd_word = res_hi_q;
            default:         rd_word = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rd_hs) begin
            rdata_q <= rd_word;
        end
    end

    assign awready_o = wr_ready_q;
    assign wready_o  = wr_ready_q;
    assign bresp_o   = 2'b00;
    assign bvalid_o  = bvalid_q;
    assign arready_o = rd_ready_q;
    assign rdata_o   = rdata_q;
    assign rresp_o   = 2'b00;
    assign rvalid_o  = rvalid_q;
    assign opa_o     = opa_q;
    assign opb_o     = opb_q;
    assign start_o   = start_q;

    a_bvalid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        bvalid_o && !bready_i |=> bvalid_o)
        else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o))
        else $error("rvalid or rdata changed before rready");

endmodule

`default_nettype wire

// File: rtl/bk_adder32.sv
`timescale 1ns/1ns
`default_nettype none

module bk_adder32 import mul_pkg::*; (
    input  word_t a_i,
    input  word_t b_i,
    input  logic  carry_i,
    output word_t sum_o,
    output logic  carry_o
);

    word_t prop;
    word_t grp_g;
    word_t grp_p;

    assign prop = a_i ^ b_i;

    always_comb begin
        grp_g = a_i & b_i;
        grp_p = prop;
        // Fold the carry in into bit 0
        grp_g[0] = grp_g[0] | (prop[0] & carry_i);

        // Up-sweep
        for (int d = 1; d < 32; d = d * 2) begin
            for (int i = d; i < 32; i++) begin
                if ((i + 1) % (2 * d) == 0) begin
                    grp_g[i] = grp_g[i] | (grp_p[i] & grp_g[i - d]);
                    grp_p[i] = grp_p[i] & grp_p[i - d];
                end
            end
        end

        // Down-sweep fills the remaining positions
        for (int d = 8; d >= 1; d = d / 2) begin
            for (int i = 2 * d; i < 32; i++) begin
                if ((i + 1) % (2 * d) == d) begin
                    grp_g[i] = grp_g[i] | (grp_p[i] & grp_g[i - d]);
                end
            end
        end
    end

    assign sum_o   = prop ^ {grp_g[30:0], carry_i};
    assign carry_o = grp_g[31];

endmodule

`default_nettype wire

// File: rtl/mul_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module mul_ctrl import mul_pkg::*; (
    input  logic clk_i,
    input  logic rst_i,
    input  logic start_i,
    input  logic prod_valid_i,
    output logic issue_o,
    output logic busy_o,
    output logic done_o
);

    mul_state_e state_q;
    mul_state_e state_d;
    logic       done_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:  if (start_i) state_d = ST_ISSUE;
            ST_ISSUE: state_d = ST_WAIT;
            ST_WAIT:  if (prod_valid_i) state_d = ST_IDLE;
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            // Sticky until the next accepted start
            if (state_q == ST_IDLE && start_i) begin
                done_q <= 1'b0;
            end else if (state_q == ST_WAIT && prod_valid_i) begin
                done_q <= 1'b1;
            end
        end
    end

    assign issue_o = (state_q == ST_ISSUE);
    assign busy_o  = (state_q != ST_IDLE);
    assign done_o  = done_q;

    a_issue_single: assert property (@(posedge clk_i) disable iff (rst_i)
        issue_o |=> !issue_o)
        else $error("issue held for more than one cycle");

    a_prod_in_wait: assert property (@(posedge clk_i) disable iff (rst_i)
        prod_valid_i |-> state_q == ST_WAIT)
        else $error("product arrived outside the wait state");

endmodule

`default_nettype wire

// File: rtl/mul_periph_top.sv
`timescale 1ns/1ns
`default_nettype none

module mul_periph_top import mul_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  addr_t       awaddr_i,
    input  logic        awvalid_i,
    output logic        awready_o,
    input  word_t       wdata_i,
    input  logic [3:0]  wstrb_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    output logic [1:0]  bresp_o,
    output logic        bvalid_o,
    input  logic        bready_i,
    input  addr_t       araddr_i,
    input  logic        arvalid_i,
    output logic        arready_o,
    output word_t       rdata_o,
    output logic [1:0]  rresp_o,
    output logic        rvalid_o,
    input  logic        rready_i
);

    word_t opa;
    word_t opb;
    logic  start;
    logic  issue;
    logic  busy;
    logic  done;
    logic  prod_valid;
    prod_t prod;

    axil_mul_regs i_axil_mul_regs (
        .clk_i, .rst_i,
        .awaddr_i, .awvalid_i, .awready_o,
        .wdata_i, .wstrb_i, .wvalid_i, .wready_o,
        .bresp_o, .bvalid_o, .bready_i,
        .araddr_i, .arvalid_i, .arready_o,
        .rdata_o, .rresp_o, .rvalid_o, .rready_i,
        .opa_o        (opa),
        .opb_o        (opb),
        .start_o      (start),
        .busy_i       (busy),
        .done_i       (done),
        .prod_valid_i (prod_valid),
        .prod_i       (prod)
    );

    mul_ctrl i_mul_ctrl (
        .clk_i, .rst_i,
        .start_i      (start),
        .prod_valid_i (prod_valid),
        .issue_o      (issue),
        .busy_o       (busy),
        .done_o       (done)
    );

    wallace_mul32 i_wallace_mul32 (
        .clk_i, .rst_i,
        .opa_i   (opa),
        .opb_i   (opb),
        .valid_i (issue),
        .prod_o  (prod),
        .valid_o (prod_valid)
    );

endmodule

`default_nettype wire

// File: rtl/mul_pkg.sv
`default_nettype none

package mul_pkg;

`include "mul_consts.svh"

    // Operand and bus data word
    typedef logic [31:0] word_t;

    // Full product, also used for carry-save rows
    typedef logic [63:0] prod_t;

    typedef logic [`MUL_ADDR_W-1:0] addr_t;

    // Controller FSM
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_ISSUE = 2'd1,
        ST_WAIT  = 2'd2
    } mul_state_e;

endpackage

`default_nettype wire

// File: rtl/wallace_mul32.sv
`timescale 1ns/1ns
`default_nettype none

`include "mul_consts.svh"

module wallace_mul32 import mul_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_i,
    input  word_t opa_i,
    input  word_t opb_i,
    input  logic  valid_i,
    output prod_t prod_o,
    output logic  valid_o
);

    typedef prod_t row_arr_t [32];

    // One level of 3:2 compressors over the first n rows.
    // Leftover rows pass through behind the compressed ones
    function automatic row_arr_t csa_level(row_arr_t rows, int n);
        row_arr_t res;
        int groups;
        groups = n / 3;
        res = '{default: '0};
        for (int g = 0; g < 10; g++) begin
            if (g < groups) begin
                res[2 * g] = rows[3 * g] ^ rows[3 * g + 1] ^ rows[3 * g + 2];
                res[2 * g + 1] = ((rows[3 * g] & rows[3 * g + 1])
                                | (rows[3 * g] & rows[3 * g + 2])
                                | (rows[3 * g + 1] & rows[3 * g + 2])) << 1;
            end
        end
        for (int r = 0; r < 2; r++) begin
            if (r < n % 3) begin
                res[2 * groups + r] = rows[3 * groups + r];
            end
        end
        return res;
    endfunction

    // *************************************************************************
    // Stage 0: magnitudes, partial products, two compressor levels
    // *************************************************************************
    word_t    opa_mag;
    word_t    opb_mag;
    row_arr_t s0_tree;
    prod_t    s0_rows [15];
    logic     s0_neg;
    logic     s0_valid;

    always_comb begin
        opa_mag = opa_i[31] ? (~opa_i + 32'd1) : opa_i;
        opb_mag = opb_i[31] ? (~opb_i + 32'd1) : opb_i;
        for (int i = 0; i < 32; i++) begin
            s0_tree[i] = opb_mag[i] ? (prod_t'(opa_mag) << i) : '0;
        end
        // 32 -> 22 -> 15 rows
        s0_tree = csa_level(s0_tree, 32);
        s0_tree = csa_level(s0_tree, 22);
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < 15; i++) begin
            s0_rows[i] <= s0_tree[i];
        end
        s0_neg <= opa_i[31] ^ opb_i[31];
    end

    // *************************************************************************
    // Stage 1: reduce to one sum row and one carry row
    // *************************************************************************
    row_arr_t s1_tree;
    prod_t    s1_sum;
    prod_t    s1_carry;
    logic     s1_neg;
    logic     s1_valid;

    always_comb begin
        s1_tree = '{default: '0};
        for (int i = 0; i < 15; i++) begin
            s1_tree[i] = s0_rows[i];
        end
        // 15 -> 10 -> 7 -> 5 -> 4 -> 3 -> 2 rows
        s1_tree = csa_level(s1_tree, 15);
        s1_tree = csa_level(s1_tree, 10);
        s1_tree = csa_level(s1_tree, 7);
        s1_tree = csa_level(s1_tree, 5);
        s1_tree = csa_level(s1_tree, 4);
        s1_tree = csa_level(s1_tree, 3);
    end

    always_ff @(posedge clk_i) begin
        s1_sum   <= s1_tree[0];
        s1_carry <= s1_tree[1];
        s1_neg   <= s0_neg;
    end

    // *************************************************************************
    // Stage 2: carry-propagate add and sign correction
    // *************************************************************************
    prod_t mag_sum;
    logic  mid_carry;
    prod_t prod_q;
    logic  valid_q;

    bk_adder32 i_add_lo (
        .a_i     (s1_sum[31:0]),
        .b_i     (s1_carry[31:0]),
        .carry_i (1'b0),
        .sum_o   (mag_sum[31:0]),
        .carry_o (mid_carry)
    );

    bk_adder32 i_add_hi (
        .a_i     (s1_sum[63:32]),
        .b_i     (s1_carry[63:32]),
        .carry_i (mid_carry),
        .sum_o   (mag_sum[63:32]),
        .carry_o ()
    );

    always_ff @(posedge clk_i) begin
        prod_q <= s1_neg ? (~mag_sum + 64'd1) : mag_sum;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            s0_valid <= 1'b0;
            s1_valid <= 1'b0;
            valid_q  <= 1'b0;
        end else begin
            s0_valid <= valid_i;
            s1_valid <= s0_valid;
            valid_q  <= s1_valid;
        end
    end

    assign prod_o  = prod_q;
    assign valid_o = valid_q;

    a_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        valid_o == $past(valid_i, `MUL_LATENCY))
        else $error("multiplier valid out does not follow valid in");

    a_prod_known: assert property (@(posedge clk_i) disable iff (rst_i)
        valid_o |-> !$isunknown(prod_o))
        else $error("multiplier product unknown while valid");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the multiplier peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module tb_mul_periph -Mdir obj_dir -o tb_mul_periph
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_mul_periph > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
